/* Makefile */
OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module tb_lsu -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/Vtb_lsu)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

/* design/input_buffer.sv */
`default_nettype none

module input_buffer (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  lsu_map_pkg::data_t i_sw,
  input  logic [3:0]         i_btn,
  input  logic [2:0]         i_idx,
  output lsu_map_pkg::data_t o_rdata
);

  import lsu_map_pkg::*;

  data_t      sw_meta;
  data_t      sw_sync;
  logic [3:0] btn_meta;
  logic [3:0] btn_sync;

  // Two flops per pin, board inputs are asynchronous
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      sw_meta  <= '0;
      sw_sync  <= '0;
      btn_meta <= '0;
      btn_sync <= '0;
    end else begin
      sw_meta  <= i_sw;
      sw_sync  <= sw_meta;
      btn_meta <= i_btn;
      btn_sync <= btn_meta;
    end
  end

  always_comb begin
    case (i_idx)
      3'(IN_SW):  o_rdata = sw_sync;
      3'(IN_BTN): o_rdata = {28'b0, btn_sync};
      default:    o_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/lsu.sv */
`default_nettype none

module lsu (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_req_valid,
  output logic                      o_req_ready,
  input  lsu_access_pkg::lsu_req_t  i_req,
  output logic                      o_rsp_valid,
  input  logic                      i_rsp_ready,
  output lsu_access_pkg::lsu_rsp_t  o_rsp,
  input  lsu_map_pkg::data_t        i_sw,
  input  logic [3:0]                i_btn,
  output lsu_map_pkg::data_t        o_ledr,
  output lsu_map_pkg::data_t        o_ledg,
  output lsu_map_pkg::hex_t [7:0]   o_hex,
  output lsu_map_pkg::data_t        o_lcd,
  output lsu_map_pkg::sram_addr_t   o_sram_addr,
  inout  wire [15:0]                io_sram_dq,
  output logic                      o_sram_ce_n,
  output logic                      o_sram_we_n,
  output logic                      o_sram_oe_n,
  output logic                      o_sram_lb_n,
  output logic                      o_sram_ub_n
);

  import lsu_map_pkg::*;
  import lsu_access_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ISSUE,  // Held request decoded and sent to one block
    S_WAIT,
    S_RESP
  } state_e;

  state_e   state_q;
  lsu_req_t req_q;
  region_e  region;
  addr_t    dmem_off;
  addr_t    out_off;
  addr_t    in_off;
  byte_en_t byte_en;
  data_t    lane_data;
  data_t    raw_data;
  data_t    ld_data;
  data_t    out_rdata;
  data_t    in_rdata;
  data_t    sram_rdata;
  logic     misaligned;
  logic     err;
  logic     sram_start;
  logic     sram_done;
  logic     out_wr;
  logic     rsp_load;

  always_comb begin
    if (req_q.addr >= DMEM_BASE && req_q.addr <= DMEM_LAST) begin
      region = REG_DMEM;
    end else if (req_q.addr >= OUT_BASE && req_q.addr <= OUT_LAST) begin
      region = REG_OUT;
    end else if (req_q.addr >= IN_BASE && req_q.addr <= IN_LAST) begin
      region = REG_IN;
    end else begin
      region = REG_NONE;
    end
  end

  assign dmem_off = req_q.addr - DMEM_BASE;
  assign out_off  = req_q.addr - OUT_BASE;
  assign in_off   = req_q.addr - IN_BASE;

  always_comb begin
    case (region)
      REG_DMEM: raw_data = sram_rdata;
      REG_OUT:  raw_data = out_rdata;
      REG_IN:   raw_data = in_rdata;
      default:  raw_data = '0;
    endcase
  end

  assign err        = misaligned || (region == REG_NONE);
  assign sram_start = (state_q == S_ISSUE) && (region == REG_DMEM) && !err;
  assign out_wr     = (state_q == S_ISSUE) && (region == REG_OUT) && req_q.write && !err;
  assign rsp_load   = ((state_q == S_ISSUE) && !sram_start) || ((state_q == S_WAIT) && sram_done);

  assign o_req_ready = (state_q == S_IDLE);
  assign o_rsp_valid = (state_q == S_RESP);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (i_req_valid) begin
            state_q <= S_ISSUE;
          end
        end
        S_ISSUE: state_q <= sram_start ? S_WAIT : S_RESP;
        S_WAIT: begin
          if (sram_done) begin
            state_q <= S_RESP;
          end
        end
        default: begin
          if (i_rsp_ready) begin
            state_q <= S_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_req_ready && i_req_valid) begin
      req_q <= i_req;
    end
    if (rsp_load) begin
      o_rsp.ld_data <= (req_q.write || err) ? '0 : ld_data;
      o_rsp.err     <= err;  // Held unchanged until taken
    end
  end

  lsu_align u_align (
    .i_addr_lo    (req_q.addr[1:0]),
    .i_op         (req_q.op),
    .i_st_data    (req_q.st_data),
    .i_raw_data   (raw_data),
    .o_byte_en    (byte_en),
    .o_lane_data  (lane_data),
    .o_misaligned (misaligned),
    .o_ld_data    (ld_data)
  );

  sram_ctrl u_sram (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_start     (sram_start),
    .i_write     (req_q.write),
    .i_word_addr ({dmem_off[18:2], 1'b0}),
    .i_byte_en   (byte_en),
    .i_wdata     (lane_data),
    .o_done      (sram_done),
    .o_rdata     (sram_rdata),
    .o_sram_addr (o_sram_addr),
    .io_sram_dq  (io_sram_dq),
    .o_sram_ce_n (o_sram_ce_n),
    .o_sram_we_n (o_sram_we_n),
    .o_sram_oe_n (o_sram_oe_n),
    .o_sram_lb_n (o_sram_lb_n),
    .o_sram_ub_n (o_sram_ub_n)
  );

  output_buffer u_out (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_wr_en   (out_wr),
    .i_idx     (out_off[5:2]),
    .i_byte_en (byte_en),
    .i_wdata   (lane_data),
    .o_rdata   (out_rdata),
    .o_ledr    (o_ledr),
    .o_ledg    (o_ledg),
    .o_hex     (o_hex),
    .o_lcd     (o_lcd)
  );

  input_buffer u_in (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_sw    (i_sw),
    .i_btn   (i_btn),
    .i_idx   (in_off[4:2]),
    .o_rdata (in_rdata)
  );

endmodule

`default_nettype wire

/* design/lsu_access_pkg.sv */
`default_nettype none

package lsu_access_pkg;

  import lsu_map_pkg::*;

  // Bits [1:0] give the size, bit 2 marks a zero-extended load
  typedef enum logic [2:0] {
    LB  = 3'd0,
    LH  = 3'd1,
    LW  = 3'd2,
    LBU = 3'd4,
    LHU = 3'd5
  } lsu_op_e;

  typedef logic [3:0] byte_en_t;

  // One memory request from the core
  typedef struct packed {
    addr_t   addr;
    logic    write;
    lsu_op_e op;
    data_t   st_data;  // Unshifted, low bytes hold the value
  } lsu_req_t;

  // One response per accepted request
  typedef struct packed {
    data_t ld_data;  // Zero for stores and errors
    logic  err;
  } lsu_rsp_t;

endpackage

`default_nettype wire

/* design/lsu_align.sv */
`default_nettype none

module lsu_align (
  input  logic [1:0]               i_addr_lo,
  input  lsu_access_pkg::lsu_op_e  i_op,
  input  lsu_map_pkg::data_t       i_st_data,
  input  lsu_map_pkg::data_t       i_raw_data,
  output lsu_access_pkg::byte_en_t o_byte_en,
  output lsu_map_pkg::data_t       o_lane_data,
  output logic                     o_misaligned,
  output lsu_map_pkg::data_t       o_ld_data
);

  import lsu_map_pkg::*;
  import lsu_access_pkg::*;

  data_t shifted;

  // Lane enables and alignment from the access size
  always_comb begin
    case (i_op[1:0])
      2'd0: begin
        o_byte_en    = 4'b0001 << i_addr_lo;
        o_misaligned = 1'b0;
      end
      2'd1: begin
        o_byte_en    = 4'b0011 << i_addr_lo;
        o_misaligned = i_addr_lo[0];
      end
      default: begin
        o_byte_en    = 4'b1111;
        o_misaligned = |i_addr_lo;
      end
    endcase
  end

  // Store bytes move up to their lane
  assign o_lane_data = i_st_data << {i_addr_lo, 3'b000};

  // Load side, addressed bytes moved down to bit 0
  assign shifted = i_raw_data >> {i_addr_lo, 3'b000};

  always_comb begin
    case (i_op)
      LB:      o_ld_data = {{24{shifted[7]}}, shifted[7:0]};
      LH:      o_ld_data = {{16{shifted[15]}}, shifted[15:0]};
      LW:      o_ld_data = shifted;
      LBU:     o_ld_data = {24'b0, shifted[7:0]};
      LHU:     o_ld_data = {16'b0, shifted[15:0]};
      default: o_ld_data = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/lsu_map_pkg.sv */
`default_nettype none

package lsu_map_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [17:0] sram_addr_t; // Halfword address on the SRAM pins
  typedef logic [6:0]  hex_t;       // Raw segment pattern

  // Data memory in external SRAM, 1 KiB
  localparam addr_t DMEM_BASE = 32'h0000_2000;
  localparam addr_t DMEM_LAST = 32'h0000_23ff;

  // Output peripheral buffer
  localparam addr_t OUT_BASE = 32'h0000_7000;
  localparam addr_t OUT_LAST = 32'h0000_703f;

  // Input peripheral buffer
  localparam addr_t IN_BASE = 32'h0000_7800;
  localparam addr_t IN_LAST = 32'h0000_781f;

  typedef enum logic [1:0] {
    REG_DMEM,
    REG_OUT,
    REG_IN,
    REG_NONE
  } region_e;

  // Word indices inside the output region
  localparam int unsigned OUT_LEDR = 0;
  localparam int unsigned OUT_LEDG = 1;
  localparam int unsigned OUT_HEX0 = 2; // Digits 0..7 at indices 2..9
  localparam int unsigned OUT_LCD  = 10;

  // Word indices inside the input region
  localparam int unsigned IN_SW  = 0;
  localparam int unsigned IN_BTN = 1;

endpackage

`default_nettype wire

/* design/output_buffer.sv */
`default_nettype none

module output_buffer (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic                         i_wr_en,
  input  logic [3:0]                   i_idx,
  input  lsu_access_pkg::byte_en_t     i_byte_en,
  input  lsu_map_pkg::data_t           i_wdata,   // Already in lane position
  output lsu_map_pkg::data_t           o_rdata,
  output lsu_map_pkg::data_t           o_ledr,
  output lsu_map_pkg::data_t           o_ledg,
  output lsu_map_pkg::hex_t [7:0]      o_hex,
  output lsu_map_pkg::data_t           o_lcd
);

  import lsu_map_pkg::*;
  import lsu_access_pkg::*;

  function automatic data_t merge_bytes(data_t old_v, data_t new_v, byte_en_t be);
    data_t res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_v[8*b +: 8];
      end
    end
    return res;
  endfunction

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ledr <= '0;
      o_ledg <= '0;
      o_hex  <= '0;
      o_lcd  <= '0;
    end else if (i_wr_en) begin
      if (i_idx == 4'(OUT_LEDR)) begin
        o_ledr <= merge_bytes(o_ledr, i_wdata, i_byte_en);
      end
      if (i_idx == 4'(OUT_LEDG)) begin
        o_ledg <= merge_bytes(o_ledg, i_wdata, i_byte_en);
      end
      if (i_idx == 4'(OUT_LCD)) begin
        o_lcd <= merge_bytes(o_lcd, i_wdata, i_byte_en);
      end
      for (int d = 0; d < 8; d++) begin
        if (i_idx == 4'(OUT_HEX0 + d) && i_byte_en[0]) begin
          o_hex[d] <= i_wdata[6:0];  // Only lane 0 holds segment bits
        end
      end
    end
  end

  always_comb begin
    o_rdata = '0;  // Unused indices read zero
    if (i_idx == 4'(OUT_LEDR)) begin
      o_rdata = o_ledr;
    end
    if (i_idx == 4'(OUT_LEDG)) begin
      o_rdata = o_ledg;
    end
    if (i_idx == 4'(OUT_LCD)) begin
      o_rdata = o_lcd;
    end
    for (int d = 0; d < 8; d++) begin
      if (i_idx == 4'(OUT_HEX0 + d)) begin
        o_rdata = {25'b0, o_hex[d]};
      end
    end
  end

endmodule

`default_nettype wire

/* design/sram_ctrl.sv */
`default_nettype none

module sram_ctrl (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_start,
  input  logic                     i_write,
  input  lsu_map_pkg::sram_addr_t  i_word_addr,  // Even halfword of the word
  input  lsu_access_pkg::byte_en_t i_byte_en,
  input  lsu_map_pkg::data_t       i_wdata,
  output logic                     o_done,
  output lsu_map_pkg::data_t       o_rdata,
  output lsu_map_pkg::sram_addr_t  o_sram_addr,
  inout  wire [15:0]               io_sram_dq,
  output logic                     o_sram_ce_n,
  output logic                     o_sram_we_n,
  output logic                     o_sram_oe_n,
  output logic                     o_sram_lb_n,
  output logic                     o_sram_ub_n
);

  import lsu_map_pkg::*;
  import lsu_access_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_LO,
    S_HI,
    S_DONE
  } state_e;

  state_e     state_q;
  logic       ph_q;     // Second cycle of a phase
  logic       wr_q;
  sram_addr_t addr_q;
  byte_en_t   be_q;
  data_t      wdata_q;
  data_t      rdata_q;
  logic       active;
  logic       in_hi;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= S_IDLE;
      ph_q    <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          ph_q <= 1'b0;
          if (i_start) begin
            if (|i_byte_en[1:0]) begin
              state_q <= S_LO;
            end else if (|i_byte_en[3:2]) begin
              state_q <= S_HI;
            end else begin
              state_q <= S_DONE;
            end
          end
        end
        S_LO: begin
          ph_q <= !ph_q;
          if (ph_q) begin
            state_q <= (|be_q[3:2]) ? S_HI : S_DONE;  // Skip an unused high half
          end
        end
        S_HI: begin
          ph_q <= !ph_q;
          if (ph_q) begin
            state_q <= S_DONE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state_q == S_IDLE && i_start) begin
      wr_q    <= i_write;
      addr_q  <= i_word_addr;
      be_q    <= i_byte_en;
      wdata_q <= i_wdata;
    end
    // Read data sampled at the end of each phase
    if (!wr_q && ph_q) begin
      if (state_q == S_LO) begin
        rdata_q[15:0] <= io_sram_dq;
      end
      if (state_q == S_HI) begin
        rdata_q[31:16] <= io_sram_dq;
      end
    end
  end

  assign active = (state_q == S_LO) || (state_q == S_HI);
  assign in_hi  = (state_q == S_HI);

  assign o_sram_addr = {addr_q[17:1], in_hi};
  assign o_sram_ce_n = !active;
  assign o_sram_oe_n = !(active && !wr_q);
  // WE pulses in the first cycle; address and data hold through the second
  assign o_sram_we_n = !(active && wr_q && !ph_q);
  assign o_sram_lb_n = !(active && (in_hi ? be_q[2] : be_q[0]));
  assign o_sram_ub_n = !(active && (in_hi ? be_q[3] : be_q[1]));

  assign io_sram_dq = (active && wr_q) ? (in_hi ? wdata_q[31:16] : wdata_q[15:0]) : 16'bz;

  assign o_done  = (state_q == S_DONE);
  assign o_rdata = rdata_q;

endmodule

`default_nettype wire

/* sources.f */
design/lsu_map_pkg.sv
design/lsu_access_pkg.sv
design/lsu_align.sv
design/sram_ctrl.sv
design/output_buffer.sv
design/input_buffer.sv
design/lsu.sv
verification/lsu_asserts.sv
verification/lsu_checker.sv
verification/tb_lsu.sv

/* verification/lsu_asserts.sv */
`default_nettype none

module lsu_asserts (
  input logic                     i_clk,
  input logic                     i_rst_n,
  input logic                     i_req_ready,
  input logic                     i_rsp_valid,
  input logic                     i_rsp_ready,
  input lsu_access_pkg::lsu_rsp_t i_rsp,
  input logic                     i_ce_n,
  input logic                     i_we_n,
  input logic                     i_oe_n
);
  timeunit 1ns;
  timeprecision 1ps;

  // Response frozen until the core takes it
  a_rsp_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_rsp_valid && !i_rsp_ready |=> i_rsp_valid && $stable(i_rsp))
    else $error("response changed or dropped under back-pressure");

  a_chip_enable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (!i_we_n || !i_oe_n) |-> !i_ce_n)
    else $error("SRAM WE or OE active without CE");

  a_no_accept: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_rsp_valid |-> !i_req_ready)
    else $error("request ready while a response is pending");

endmodule

`default_nettype wire

/* verification/lsu_checker.sv */
`default_nettype none

module lsu_checker (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_req_valid,
  input  logic                     i_req_ready,
  input  lsu_access_pkg::lsu_req_t i_req,
  input  logic                     i_rsp_valid,
  input  logic                     i_rsp_ready,
  input  lsu_access_pkg::lsu_rsp_t i_rsp,
  input  lsu_map_pkg::data_t       i_sw,
  input  logic [3:0]               i_btn,
  input  lsu_map_pkg::data_t       i_ledr,
  input  lsu_map_pkg::data_t       i_ledg,
  input  lsu_map_pkg::hex_t [7:0]  i_hex,
  input  lsu_map_pkg::data_t       i_lcd,
  output int                       o_errors,
  output int                       o_checks
);
  timeunit 1ns;
  timeprecision 1ps;

  import lsu_map_pkg::*;
  import lsu_access_pkg::*;

  logic [7:0] dmem [0:1023];
  logic [7:0] outm [0:63];   // Output region as bytes with ignored bits kept zero
  lsu_rsp_t   exp_q[$];
  lsu_rsp_t   exp_rsp;

  function automatic logic [7:0] fill_byte(int addr);
    return 8'(addr ^ (addr >> 3) ^ 8'h6c);
  endfunction

  function automatic int acc_size(lsu_op_e op);
    if (op == LB || op == LBU) return 1;
    if (op == LH || op == LHU) return 2;
    return 4;
  endfunction

  function automatic bit is_mapped(addr_t a);
    return (a >= DMEM_BASE && a <= DMEM_LAST) || (a >= OUT_BASE && a <= OUT_LAST)
        || (a >= IN_BASE && a <= IN_LAST);
  endfunction

  function automatic logic [7:0] read_byte(addr_t a);
    data_t w;
    if (a >= DMEM_BASE && a <= DMEM_LAST) return dmem[10'(a - DMEM_BASE)];
    if (a >= OUT_BASE && a <= OUT_LAST) return outm[6'(a - OUT_BASE)];
    w = '0;
    if (a[4:2] == 3'(IN_SW)) w = i_sw;
    if (a[4:2] == 3'(IN_BTN)) w = {28'b0, i_btn};
    return w[8 * a[1:0] +: 8];
  endfunction

  // Expected response straight from the address map rules
  function automatic lsu_rsp_t ref_rsp(lsu_req_t r);
    lsu_rsp_t res;
    int       n;
    n       = acc_size(r.op);
    res.err = !is_mapped(r.addr) || (r.addr % n != 0);
    res.ld_data = '0;
    if (res.err || r.write) return res;
    for (int i = 0; i < n; i++) res.ld_data[8 * i +: 8] = read_byte(r.addr + i);
    if (r.op == LB) res.ld_data = {{24{res.ld_data[7]}}, res.ld_data[7:0]};
    if (r.op == LH) res.ld_data = {{16{res.ld_data[15]}}, res.ld_data[15:0]};
    return res;
  endfunction

  task automatic write_byte(addr_t a, logic [7:0] v);
    logic [5:0] off;
    if (a >= DMEM_BASE && a <= DMEM_LAST) dmem[10'(a - DMEM_BASE)] = v;
    if (a >= OUT_BASE && a <= OUT_LAST) begin
      off = 6'(a - OUT_BASE);
      if (off[5:2] <= 4'(OUT_LEDG) || off[5:2] == 4'(OUT_LCD)) outm[off] = v;
      else if (off[5:2] <= 4'(OUT_HEX0 + 7) && off[1:0] == 2'd0) outm[off] = {1'b0, v[6:0]};
    end
  endtask

  function automatic data_t out_word(int idx);
    return {outm[4 * idx + 3], outm[4 * idx + 2], outm[4 * idx + 1], outm[4 * idx]};
  endfunction

  task automatic compare(string what, data_t got, data_t exp);
    o_checks++;
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      o_errors++;
    end
  endtask

  always @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 1024; i++) dmem[i] = fill_byte(i);
      for (int i = 0; i < 64; i++) outm[i] = '0;
      exp_q.delete();
      o_errors = 0;
      o_checks = 0;
    end else begin
      if (i_req_valid && i_req_ready) begin
        exp_q.push_back(ref_rsp(i_req));
        if (i_req.write && !exp_q[$].err) begin
          for (int i = 0; i < acc_size(i_req.op); i++) begin
            write_byte(i_req.addr + i, i_req.st_data[8 * i +: 8]);
          end
        end
      end
      if (i_rsp_valid && i_rsp_ready) begin
        if (exp_q.size() == 0) begin
          $display("Response at %0t arrived with no request outstanding", $time);
          o_errors++;
        end else begin
          exp_rsp = exp_q.pop_front();
          compare("load data", i_rsp.ld_data, exp_rsp.ld_data);
          compare("error flag", 32'(i_rsp.err), 32'(exp_rsp.err));
        end
        // Pins must always match the model
        compare("LEDR pins", i_ledr, out_word(OUT_LEDR));
        compare("LEDG pins", i_ledg, out_word(OUT_LEDG));
        compare("LCD pins", i_lcd, out_word(OUT_LCD));
        for (int d = 0; d < 8; d++) begin
          compare("HEX pins", 32'(i_hex[d]), out_word(OUT_HEX0 + d));
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verification/tb_lsu.sv */
`default_nettype none

module tb_lsu;
  timeunit 1ns;
  timeprecision 1ps;

  import lsu_map_pkg::*;
  import lsu_access_pkg::*;

  localparam int TIMEOUT = 200;

  logic                    clk;
  logic                    rst_n;
  logic                    req_valid;
  logic                    req_ready;
  lsu_req_t                req;
  logic                    rsp_valid;
  logic                    rsp_ready;
  lsu_rsp_t                rsp;
  data_t                   sw;
  logic [3:0]              btn;
  data_t                   ledr;
  data_t                   ledg;
  hex_t [7:0]              hex;
  data_t                   lcd;
  sram_addr_t              sram_addr;
  wire [15:0]              sram_dq;
  logic                    ce_n;
  logic                    we_n;
  logic                    oe_n;
  logic                    lb_n;
  logic                    ub_n;
  int                      chk_errors;
  int                      chk_checks;

  logic [15:0] sram_mem [0:511];
  logic [8:0]  hw;
  int          seed;
  bit          bp_on;
  bit          timed_out;
  int          tb_errors;
  int          test_num;
  addr_t       addrs[$];
  addr_t       a;
  int          r;

  always #2 clk = ~clk;

  lsu uut (
    .i_clk(clk), .i_rst_n(rst_n), .i_req_valid(req_valid), .o_req_ready(req_ready),
    .i_req(req), .o_rsp_valid(rsp_valid), .i_rsp_ready(rsp_ready), .o_rsp(rsp),
    .i_sw(sw), .i_btn(btn), .o_ledr(ledr), .o_ledg(ledg), .o_hex(hex), .o_lcd(lcd),
    .o_sram_addr(sram_addr), .io_sram_dq(sram_dq), .o_sram_ce_n(ce_n),
    .o_sram_we_n(we_n), .o_sram_oe_n(oe_n), .o_sram_lb_n(lb_n), .o_sram_ub_n(ub_n)
  );

  lsu_checker chk (
    .i_clk(clk), .i_rst_n(rst_n), .i_req_valid(req_valid), .i_req_ready(req_ready),
    .i_req(req), .i_rsp_valid(rsp_valid), .i_rsp_ready(rsp_ready), .i_rsp(rsp),
    .i_sw(sw), .i_btn(btn), .i_ledr(ledr), .i_ledg(ledg), .i_hex(hex), .i_lcd(lcd),
    .o_errors(chk_errors), .o_checks(chk_checks)
  );

  bind lsu lsu_asserts u_asserts (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_req_ready(o_req_ready),
    .i_rsp_valid(o_rsp_valid), .i_rsp_ready(i_rsp_ready), .i_rsp(o_rsp),
    .i_ce_n(o_sram_ce_n), .i_we_n(o_sram_we_n), .i_oe_n(o_sram_oe_n)
  );

  // Same pattern as the checker model
  function automatic logic [7:0] fill_byte(int addr);
    return 8'(addr ^ (addr >> 3) ^ 8'h6c);
  endfunction

  // Async SRAM model with write lanes taken while WE is low
  assign hw      = sram_addr[8:0];
  assign sram_dq = (!ce_n && !oe_n && we_n) ? sram_mem[hw] : 16'bz;

  always @(posedge clk) begin
    if (!ce_n && !we_n) begin
      if (!lb_n) sram_mem[hw][7:0] <= sram_dq[7:0];
      if (!ub_n) sram_mem[hw][15:8] <= sram_dq[15:8];
    end
  end

  always @(negedge clk) begin
    rsp_ready <= bp_on ? (($random(seed) & 3) == 0) : 1'b1;
  end

  task automatic report_timeout(string what);
    $display("Timeout: no %s within %0d cycles", what, TIMEOUT);
    timed_out = 1'b1;
  endtask

  // A stalled wait ends the run
  always @(posedge timed_out) begin
    $display("ERRORS FOUND");
    $finish;
  end

  task automatic access(addr_t addr, logic wr, lsu_op_e op, data_t d);
    int n;
    @(negedge clk);
    req       = '{addr: addr, write: wr, op: op, st_data: d};
    req_valid = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("request ready");
    end while (!req_ready);
    @(negedge clk);
    req_valid = 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("response handshake");
    end while (!(rsp_valid && rsp_ready));
  endtask

  task automatic end_test(string name);
    @(negedge clk);
    test_num++;
    if (rsp_valid || !req_ready) begin
      $display("Test %0d left the unit busy after its last response", test_num);
      tb_errors++;
    end
    $display("test %0d %s done, errors so far %0d", test_num, name, chk_errors + tb_errors);
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b1;
    sw        = '0;
    btn       = '0;
    bp_on     = 1'b0;
    timed_out = 1'b0;
    seed      = 32'h8f36752e;
    tb_errors = 0;
    test_num  = 0;
    for (int h = 0; h < 512; h++) begin
      sram_mem[h] = {fill_byte(2 * h + 1), fill_byte(2 * h)};
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < 12; i++) begin
      a = DMEM_BASE + (addr_t'($random(seed)) & 32'h3fc);
      addrs.push_back(a);
      access(a, 1'b1, LW, $random(seed));
    end
    foreach (addrs[i]) access(addrs[i], 1'b0, LW, '0);
    end_test("word store and load");

    a = DMEM_BASE + 32'h10;
    access(a, 1'b1, LW, 32'h1234_5678);
    for (int b = 0; b < 4; b++) access(a + b, 1'b1, LB, $random(seed));
    access(a + 4, 1'b1, LW, 32'h0f0f_0f0f);
    access(a + 4, 1'b1, LH, 32'h0000_8181);
    access(a + 6, 1'b1, LH, 32'h0000_7e90);
    for (int b = 0; b < 8; b++) begin
      access(a + b, 1'b0, LB, '0);
      access(a + b, 1'b0, LBU, '0);
    end
    for (int b = 0; b < 8; b += 2) begin
      access(a + b, 1'b0, LH, '0);
      access(a + b, 1'b0, LHU, '0);
    end
    access(a, 1'b0, LW, '0);
    access(a + 4, 1'b0, LW, '0);
    end_test("byte and halfword merge");

    access(OUT_BASE + 32'(4 * OUT_LEDR), 1'b1, LW, $random(seed));
    access(OUT_BASE + 32'(4 * OUT_LEDG), 1'b1, LW, $random(seed));
    access(OUT_BASE + 32'(4 * OUT_LCD), 1'b1, LW, $random(seed));
    access(OUT_BASE + 32'(4 * OUT_LEDR) + 2, 1'b1, LH, $random(seed));
    access(OUT_BASE + 32'(4 * OUT_LCD) + 1, 1'b1, LB, $random(seed));
    for (int d = 0; d < 8; d++) begin
      access(OUT_BASE + 32'(4 * (OUT_HEX0 + d)), 1'b1, LB, $random(seed));
    end
    access(OUT_BASE + 32'(4 * OUT_HEX0), 1'b1, LW, 32'hffff_ffff);
    access(OUT_BASE + 32'h30, 1'b1, LW, 32'hdead_beef);  // Unused index
    for (int w = 0; w < 16; w++) access(OUT_BASE + 32'(4 * w), 1'b0, LW, '0);
    access(OUT_BASE + 32'h3, 1'b0, LB, '0);
    end_test("output peripherals");

    for (int k = 0; k < 3; k++) begin
      @(negedge clk);
      sw  = $random(seed);
      btn = 4'($random(seed));
      repeat (4) @(negedge clk);  // Synchronizer settles
      access(IN_BASE + 32'(4 * IN_SW), 1'b0, LW, '0);
      access(IN_BASE + 32'(4 * IN_BTN), 1'b0, LW, '0);
      access(IN_BASE + 32'(4 * IN_SW) + 1, 1'b0, LB, '0);
      access(IN_BASE + 32'(4 * IN_SW) + 2, 1'b0, LH, '0);
      access(IN_BASE + 32'(4 * IN_BTN), 1'b0, LBU, '0);
      access(IN_BASE + 32'h8, 1'b0, LW, '0);
    end
    end_test("input peripherals");

    access(32'h0000_0000, 1'b0, LW, '0);
    access(32'h0000_3000, 1'b1, LW, 32'hffff_ffff);
    access(DMEM_BASE + 2, 1'b1, LW, 32'hffff_ffff);
    access(DMEM_BASE + 1, 1'b1, LH, 32'hffff_ffff);
    access(DMEM_BASE + 3, 1'b0, LHU, '0);
    access(OUT_BASE + 1, 1'b1, LW, 32'hffff_ffff);
    access(OUT_LAST + 1, 1'b1, LW, 32'hffff_ffff);
    access(IN_LAST + 1, 1'b0, LB, '0);
    access(DMEM_BASE, 1'b0, LW, '0);
    access(DMEM_BASE + 4, 1'b0, LW, '0);
    access(OUT_BASE, 1'b0, LW, '0);
    end_test("error responses");

    bp_on = 1'b1;
    for (int i = 0; i < 24; i++) begin
      r = $random(seed) & 7;
      if (r < 5) begin
        a = DMEM_BASE + (addr_t'($random(seed)) & 32'h3fc);
      end else begin
        a = OUT_BASE + 32'(4 * (r - 5) * 5);  // LEDR, HEX3 or LCD
      end
      if ($random(seed) & 1) begin
        access(a, 1'b1, lsu_op_e'(3'($random(seed) & 1) + 3'(r & 1)), $random(seed));
      end else begin
        access(a, 1'b0, (r & 1) ? LHU : LW, '0);
      end
    end
    bp_on = 1'b0;
    end_test("response back-pressure");

    $display("tests %0d, checks %0d, errors %0d", test_num, chk_checks, chk_errors + tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
